// ==== audio_pkg.sv ====
`default_nettype none

package audio_pkg;

	// recorder state codes
	localparam int STATE_W = 4;
	localparam logic [STATE_W-1:0] ST_IDLE       = 4'd0;
	localparam logic [STATE_W-1:0] ST_REC        = 4'd1;
	localparam logic [STATE_W-1:0] ST_REC_PAUSE  = 4'd2;
	localparam logic [STATE_W-1:0] ST_PLAY       = 4'd3;
	localparam logic [STATE_W-1:0] ST_PLAY_PAUSE = 4'd4;

	// datapath widths
	localparam int SAMPLE_W = 16;
	localparam int ADDR_W   = 20;
	localparam int SPEED_W  = 3;

	// stable cycles before a key level is taken
	localparam int DEBOUNCE_CYCLES = 16;

	// 4096 / f rounded, indexed by the speed factor f
	localparam int RECIP_SHIFT = 12;
	localparam logic [12:0] RECIP_Q12 [1:8] = '{
		13'd4096,
		13'd2048,
		13'd1365,
		13'd1024,
		13'd819,
		13'd683,
		13'd585,
		13'd512
	};

endpackage

`default_nettype wire

// ==== key_debounce.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_debounce (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_in,
	output logic o_neg
);

	logic [1:0] sync;
	logic level;
	logic [$clog2(audio_pkg::DEBOUNCE_CYCLES)-1:0] cnt;
	logic settle;

	// new level held for the whole window
	assign settle = (sync[1] != level) && (cnt == audio_pkg::DEBOUNCE_CYCLES - 1);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			sync  <= 2'b11;
			level <= 1'b1;
			cnt   <= '0;
			o_neg <= 1'b0;
		end else begin
			sync  <= {sync[0], i_in};
			o_neg <= settle && !sync[1];
			if (sync[1] == level || settle) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
			if (settle) begin
				level <= sync[1];
			end
		end
	end

endmodule

`default_nettype wire

// ==== i2s_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2s_capture (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_bclk,
	input  logic i_lrck,
	input  logic i_adcdat,
	output logic o_smp_valid,
	output logic [audio_pkg::SAMPLE_W-1:0] o_smp
);

	logic [2:0] bclk_s;
	logic [2:0] lrck_s;
	logic [1:0] dat_s;
	logic bclk_rise;
	logic lrck_fall;
	logic busy;
	logic skip;
	logic last;
	logic [$clog2(audio_pkg::SAMPLE_W)-1:0] bit_cnt;

	assign bclk_rise = bclk_s[1] && !bclk_s[2];
	assign lrck_fall = !lrck_s[1] && lrck_s[2];

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			bclk_s      <= '0;
			lrck_s      <= '0;
			dat_s       <= '0;
			busy        <= 1'b0;
			skip        <= 1'b0;
			bit_cnt     <= '0;
			last        <= 1'b0;
			o_smp_valid <= 1'b0;
		end else begin
			bclk_s      <= {bclk_s[1:0], i_bclk};
			lrck_s      <= {lrck_s[1:0], i_lrck};
			dat_s       <= {dat_s[0], i_adcdat};
			o_smp_valid <= last;
			last        <= bclk_rise && busy && !skip && (&bit_cnt) && !lrck_fall;
			// left half starts, first rise is the I2S delay slot
			if (lrck_fall) begin
				busy    <= 1'b1;
				skip    <= 1'b1;
				bit_cnt <= '0;
			end else if (bclk_rise && busy) begin
				if (skip) begin
					skip <= 1'b0;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
					if (&bit_cnt) begin
						busy <= 1'b0;
					end
				end
			end
		end
	end

	// MSB first
	always_ff @(posedge i_clk) begin
		if (bclk_rise && busy && !skip && !lrck_fall) begin
			o_smp <= {o_smp[audio_pkg::SAMPLE_W-2:0], dat_s[1]};
		end
	end

endmodule

`default_nettype wire

// ==== i2s_playback.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2s_playback (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_bclk,
	input  logic i_lrck,
	input  logic i_valid,
	input  logic [audio_pkg::SAMPLE_W-1:0] i_smp,
	output logic o_dac_req,
	output logic o_dacdat
);

	logic [2:0] bclk_s;
	logic [2:0] lrck_s;
	logic bclk_fall;
	logic lrck_fall;
	logic busy;
	logic [$clog2(audio_pkg::SAMPLE_W)-1:0] bit_cnt;
	logic [audio_pkg::SAMPLE_W-1:0] shreg;

	assign bclk_fall = !bclk_s[1] && bclk_s[2];
	assign lrck_fall = !lrck_s[1] && lrck_s[2];

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			bclk_s    <= '0;
			lrck_s    <= '0;
			busy      <= 1'b0;
			bit_cnt   <= '0;
			shreg     <= '0;
			o_dac_req <= 1'b0;
			o_dacdat  <= 1'b0;
		end else begin
			bclk_s    <= {bclk_s[1:0], i_bclk};
			lrck_s    <= {lrck_s[1:0], i_lrck};
			o_dac_req <= lrck_fall;
			// word arrives well before the first BCLK fall of the frame
			if (i_valid) begin
				shreg <= i_smp;
			end
			if (lrck_fall) begin
				busy    <= 1'b1;
				bit_cnt <= '0;
			end else if (bclk_fall) begin
				if (busy) begin
					o_dacdat <= shreg[audio_pkg::SAMPLE_W-1];
					shreg    <= {shreg[audio_pkg::SAMPLE_W-2:0], 1'b0};
					bit_cnt  <= bit_cnt + 1'b1;
					busy     <= ~&bit_cnt;
				end else begin
					// right half stays silent
					o_dacdat <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== rec_play_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module rec_play_ctrl (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_start,
	input  logic i_pause,
	input  logic i_stop,
	input  logic i_smp_valid,
	input  logic i_play_done,
	output logic [audio_pkg::STATE_W-1:0] o_state,
	output logic o_wr_en,
	output logic [audio_pkg::ADDR_W-1:0] o_wr_addr,
	output logic [audio_pkg::ADDR_W-1:0] o_end_addr,
	output logic o_play_run,
	output logic o_play_rst
);

	logic [audio_pkg::ADDR_W-1:0] last_addr;
	logic [audio_pkg::ADDR_W-1:0] final_addr;
	logic rec_any;
	logic has_rec;

	assign o_wr_en    = i_smp_valid && (o_state == audio_pkg::ST_REC);
	assign o_play_run = (o_state == audio_pkg::ST_PLAY);
	// a write in the stop cycle still counts
	assign final_addr = o_wr_en ? o_wr_addr : last_addr;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_state    <= audio_pkg::ST_IDLE;
			o_wr_addr  <= '0;
			o_end_addr <= '0;
			last_addr  <= '0;
			rec_any    <= 1'b0;
			has_rec    <= 1'b0;
			o_play_rst <= 1'b0;
		end else begin
			o_play_rst <= 1'b0;
			if (o_wr_en) begin
				last_addr <= o_wr_addr;
				rec_any   <= 1'b1;
				// saturate at the top of memory
				if (o_wr_addr != '1) begin
					o_wr_addr <= o_wr_addr + 1'b1;
				end
			end
			case (o_state)
				audio_pkg::ST_IDLE: begin
					if (i_start) begin
						o_state   <= audio_pkg::ST_REC;
						o_wr_addr <= '0;
						rec_any   <= 1'b0;
					end else if (i_pause && has_rec) begin
						o_state    <= audio_pkg::ST_PLAY;
						o_play_rst <= 1'b1;
					end
				end
				audio_pkg::ST_REC, audio_pkg::ST_REC_PAUSE: begin
					if (i_stop) begin
						o_state    <= audio_pkg::ST_IDLE;
						o_end_addr <= final_addr;
						has_rec    <= rec_any || o_wr_en;
					end else if (i_pause) begin
						o_state <= (o_state == audio_pkg::ST_REC) ?
							audio_pkg::ST_REC_PAUSE : audio_pkg::ST_REC;
					end
				end
				audio_pkg::ST_PLAY: begin
					if (i_stop || i_play_done) begin
						o_state <= audio_pkg::ST_IDLE;
					end else if (i_pause) begin
						o_state <= audio_pkg::ST_PLAY_PAUSE;
					end
				end
				audio_pkg::ST_PLAY_PAUSE: begin
					if (i_stop) begin
						o_state <= audio_pkg::ST_IDLE;
					end else if (i_pause) begin
						o_state <= audio_pkg::ST_PLAY;
					end
				end
				default: begin
					o_state <= audio_pkg::ST_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== aud_speed_dsp.sv ====
`timescale 1ns/1ps
`default_nettype none

module aud_speed_dsp (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_run,
	input  logic i_restart,
	input  logic [audio_pkg::SPEED_W-1:0] i_speed,
	input  logic i_fast,
	input  logic i_interp,
	input  logic [audio_pkg::ADDR_W-1:0] i_end_addr,
	input  logic i_dac_req,
	input  logic [audio_pkg::SAMPLE_W-1:0] i_rd_data,
	output logic [audio_pkg::ADDR_W-1:0] o_rd_addr,
	output logic o_out_valid,
	output logic [audio_pkg::SAMPLE_W-1:0] o_out_smp,
	output logic o_done,
	output logic [audio_pkg::ADDR_W-1:0] o_play_pos
);

	logic [audio_pkg::SPEED_W:0] factor;
	logic [audio_pkg::SPEED_W:0] step;
	logic [audio_pkg::SPEED_W-1:0] phase;
	logic last_phase;
	logic rd_pend;
	logic [audio_pkg::SAMPLE_W-1:0] prev_w;
	logic [audio_pkg::ADDR_W:0] next_addr;
	logic signed [audio_pkg::SAMPLE_W+4:0] mix;
	logic signed [audio_pkg::SAMPLE_W+18:0] scaled;
	logic [audio_pkg::SAMPLE_W-1:0] interp_smp;

	assign factor     = {1'b0, i_speed} + 1'b1;
	assign last_phase = (phase >= i_speed);
	assign o_play_pos = o_rd_addr;

	// fast skips f words, slow moves one word after f requests
	assign step      = i_fast ? factor : {{audio_pkg::SPEED_W{1'b0}}, last_phase};
	assign next_addr = {1'b0, o_rd_addr}
		+ {{(audio_pkg::ADDR_W-audio_pkg::SPEED_W){1'b0}}, step};

	// prev*(f-k) + next*k, scaled by 1/f in Q12
	assign mix = $signed(prev_w) * $signed({1'b0, factor - {1'b0, phase}})
		+ $signed(i_rd_data) * $signed({1'b0, phase});
	assign scaled     = mix * $signed({1'b0, audio_pkg::RECIP_Q12[factor]});
	assign interp_smp = scaled[audio_pkg::RECIP_SHIFT +: audio_pkg::SAMPLE_W];

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_rd_addr   <= '0;
			phase       <= '0;
			prev_w      <= '0;
			rd_pend     <= 1'b0;
			o_out_valid <= 1'b0;
			o_done      <= 1'b0;
		end else begin
			o_out_valid <= rd_pend;
			o_done      <= 1'b0;
			rd_pend     <= i_dac_req && i_run && !i_restart;
			if (i_restart) begin
				o_rd_addr <= '0;
				phase     <= '0;
				prev_w    <= '0;
			end else if (rd_pend) begin
				// read data for the current address is valid now
				o_done    <= (next_addr > {1'b0, i_end_addr});
				o_rd_addr <= next_addr[audio_pkg::ADDR_W-1:0];
				if (i_fast || last_phase) begin
					phase  <= '0;
					prev_w <= i_rd_data;
				end else begin
					phase <= phase + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (rd_pend) begin
			o_out_smp <= (i_fast || !i_interp) ? i_rd_data : interp_smp;
		end
	end

endmodule

`default_nettype wire

// ==== audio_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module audio_core (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_start,
	input  logic i_pause,
	input  logic i_stop,
	input  logic [audio_pkg::SPEED_W-1:0] i_dsp_speed,
	input  logic i_dsp_fast,
	input  logic i_dsp_interp,
	output logic [audio_pkg::ADDR_W-1:0] o_sram_addr,
	inout  wire  [audio_pkg::SAMPLE_W-1:0] io_sram_dq,
	output logic o_sram_we_n,
	output logic o_sram_ce_n,
	output logic o_sram_oe_n,
	output logic o_sram_lb_n,
	output logic o_sram_ub_n,
	input  logic i_aud_adcdat,
	input  logic i_aud_adclrck,
	input  logic i_aud_bclk,
	input  logic i_aud_daclrck,
	output logic o_aud_dacdat,
	output logic [audio_pkg::STATE_W-1:0] o_state,
	output logic [3:0] o_play_time,
	output logic [15:0] o_end_address
);

	logic smp_valid;
	logic [audio_pkg::SAMPLE_W-1:0] smp;
	logic wr_en;
	logic [audio_pkg::ADDR_W-1:0] wr_addr;
	logic [audio_pkg::ADDR_W-1:0] end_addr;
	logic play_run;
	logic play_rst;
	logic play_done;
	logic dac_req;
	logic [audio_pkg::ADDR_W-1:0] rd_addr;
	logic [audio_pkg::ADDR_W-1:0] play_pos;
	logic out_valid;
	logic [audio_pkg::SAMPLE_W-1:0] out_smp;
	logic recording;

	i2s_capture u_capture (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_bclk      (i_aud_bclk),
		.i_lrck      (i_aud_adclrck),
		.i_adcdat    (i_aud_adcdat),
		.o_smp_valid (smp_valid),
		.o_smp       (smp)
	);

	rec_play_ctrl u_ctrl (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_start     (i_start),
		.i_pause     (i_pause),
		.i_stop      (i_stop),
		.i_smp_valid (smp_valid),
		.i_play_done (play_done),
		.o_state     (o_state),
		.o_wr_en     (wr_en),
		.o_wr_addr   (wr_addr),
		.o_end_addr  (end_addr),
		.o_play_run  (play_run),
		.o_play_rst  (play_rst)
	);

	aud_speed_dsp u_dsp (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_run       (play_run),
		.i_restart   (play_rst),
		.i_speed     (i_dsp_speed),
		.i_fast      (i_dsp_fast),
		.i_interp    (i_dsp_interp),
		.i_end_addr  (end_addr),
		.i_dac_req   (dac_req),
		.i_rd_data   (io_sram_dq),
		.o_rd_addr   (rd_addr),
		.o_out_valid (out_valid),
		.o_out_smp   (out_smp),
		.o_done      (play_done),
		.o_play_pos  (play_pos)
	);

	i2s_playback u_playback (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_bclk    (i_aud_bclk),
		.i_lrck    (i_aud_daclrck),
		.i_valid   (out_valid),
		.i_smp     (out_smp),
		.o_dac_req (dac_req),
		.o_dacdat  (o_aud_dacdat)
	);

	assign recording = (o_state == audio_pkg::ST_REC) || (o_state == audio_pkg::ST_REC_PAUSE);

	// SRAM is read whenever no write is in flight
	assign o_sram_addr = recording ? wr_addr : rd_addr;
	assign io_sram_dq  = wr_en ? smp : 'z;
	assign o_sram_we_n = !wr_en;
	assign o_sram_oe_n = wr_en;
	assign o_sram_ce_n = 1'b0;
	assign o_sram_lb_n = 1'b0;
	assign o_sram_ub_n = 1'b0;

	assign o_play_time   = play_pos[19:16];
	assign o_end_address = end_addr[19:4];

endmodule

`default_nettype wire

// ==== seg7_status.sv ====
`timescale 1ns/1ps
`default_nettype none

module seg7_status (
	input  logic i_fast,
	input  logic [audio_pkg::SPEED_W-1:0] i_speed,
	input  logic [3:0] i_play_time,
	input  logic [15:0] i_end_address,
	input  logic [audio_pkg::STATE_W-1:0] i_state,
	output logic [6:0] o_hex0,
	output logic [6:0] o_hex1,
	output logic [6:0] o_hex2,
	output logic [6:0] o_hex3,
	output logic [6:0] o_hex4,
	output logic [6:0] o_hex5,
	output logic [6:0] o_hex6,
	output logic [6:0] o_hex7,
	output logic [8:0] o_ledg
);

	logic pt_tens;
	logic [3:0] pt_ones;

	// active low, segment g in bit 6
	function automatic logic [6:0] hex_seg(input logic [3:0] h);
		case (h)
			4'h0: hex_seg = 7'b1000000;
			4'h1: hex_seg = 7'b1111001;
			4'h2: hex_seg = 7'b0100100;
			4'h3: hex_seg = 7'b0110000;
			4'h4: hex_seg = 7'b0011001;
			4'h5: hex_seg = 7'b0010010;
			4'h6: hex_seg = 7'b0000010;
			4'h7: hex_seg = 7'b1111000;
			4'h8: hex_seg = 7'b0000000;
			4'h9: hex_seg = 7'b0010000;
			4'ha: hex_seg = 7'b0001000;
			4'hb: hex_seg = 7'b0000011;
			4'hc: hex_seg = 7'b1000110;
			4'hd: hex_seg = 7'b0100001;
			4'he: hex_seg = 7'b0000110;
			default: hex_seg = 7'b0001110;
		endcase
	endfunction

	// play time as two decimal digits
	assign pt_tens = (i_play_time > 4'd9);
	assign pt_ones = pt_tens ? i_play_time - 4'd10 : i_play_time;

	assign o_hex0 = hex_seg(i_end_address[3:0]);
	assign o_hex1 = hex_seg(i_end_address[7:4]);
	assign o_hex2 = hex_seg(i_end_address[11:8]);
	assign o_hex3 = hex_seg(i_end_address[15:12]);
	assign o_hex4 = hex_seg(pt_ones);
	assign o_hex5 = hex_seg({3'b000, pt_tens});
	// speed factor, 1 to 8
	assign o_hex6 = hex_seg({1'b0, i_speed} + 4'd1);
	// dash marks slow mode
	assign o_hex7 = i_fast ? 7'b1111111 : 7'b0111111;

	assign o_ledg[0]   = (i_state == audio_pkg::ST_IDLE);
	assign o_ledg[1]   = (i_state == audio_pkg::ST_REC);
	assign o_ledg[2]   = (i_state == audio_pkg::ST_REC_PAUSE);
	assign o_ledg[3]   = (i_state == audio_pkg::ST_PLAY);
	assign o_ledg[4]   = (i_state == audio_pkg::ST_PLAY_PAUSE);
	assign o_ledg[8:5] = 4'b0000;

endmodule

`default_nettype wire

// ==== audio_board.sv ====
`timescale 1ns/1ps
`default_nettype none

module audio_board (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic [2:0] i_key,
	input  logic [17:0] i_sw,
	output logic [audio_pkg::ADDR_W-1:0] o_sram_addr,
	inout  wire  [audio_pkg::SAMPLE_W-1:0] io_sram_dq,
	output logic o_sram_we_n,
	output logic o_sram_ce_n,
	output logic o_sram_oe_n,
	output logic o_sram_lb_n,
	output logic o_sram_ub_n,
	input  logic i_aud_adcdat,
	input  logic i_aud_adclrck,
	input  logic i_aud_bclk,
	input  logic i_aud_daclrck,
	output logic o_aud_dacdat,
	output logic [6:0] o_hex0,
	output logic [6:0] o_hex1,
	output logic [6:0] o_hex2,
	output logic [6:0] o_hex3,
	output logic [6:0] o_hex4,
	output logic [6:0] o_hex5,
	output logic [6:0] o_hex6,
	output logic [6:0] o_hex7,
	output logic [8:0] o_ledg,
	output logic [17:0] o_ledr
);

	logic key_stop;
	logic key_play;
	logic key_start;
	logic [audio_pkg::STATE_W-1:0] state;
	logic [3:0] play_time;
	logic [15:0] end_address;

	assign o_ledr = i_sw;

	// key 0 stop
	key_debounce u_deb_stop (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_in    (i_key[0]),
		.o_neg   (key_stop)
	);

	// key 1 play and pause
	key_debounce u_deb_play (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_in    (i_key[1]),
		.o_neg   (key_play)
	);

	// key 2 start recording
	key_debounce u_deb_start (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_in    (i_key[2]),
		.o_neg   (key_start)
	);

	audio_core u_core (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_start       (key_start),
		.i_pause       (key_play),
		.i_stop        (key_stop),
		.i_dsp_speed   (i_sw[16:14]),
		.i_dsp_fast    (i_sw[12]),
		.i_dsp_interp  (i_sw[11]),
		.o_sram_addr   (o_sram_addr),
		.io_sram_dq    (io_sram_dq),
		.o_sram_we_n   (o_sram_we_n),
		.o_sram_ce_n   (o_sram_ce_n),
		.o_sram_oe_n   (o_sram_oe_n),
		.o_sram_lb_n   (o_sram_lb_n),
		.o_sram_ub_n   (o_sram_ub_n),
		.i_aud_adcdat  (i_aud_adcdat),
		.i_aud_adclrck (i_aud_adclrck),
		.i_aud_bclk    (i_aud_bclk),
		.i_aud_daclrck (i_aud_daclrck),
		.o_aud_dacdat  (o_aud_dacdat),
		.o_state       (state),
		.o_play_time   (play_time),
		.o_end_address (end_address)
	);

	seg7_status u_status (
		.i_fast        (i_sw[12]),
		.i_speed       (i_sw[16:14]),
		.i_play_time   (play_time),
		.i_end_address (end_address),
		.i_state       (state),
		.o_hex0        (o_hex0),
		.o_hex1        (o_hex1),
		.o_hex2        (o_hex2),
		.o_hex3        (o_hex3),
		.o_hex4        (o_hex4),
		.o_hex5        (o_hex5),
		.o_hex6        (o_hex6),
		.o_hex7        (o_hex7),
		.o_ledg        (o_ledg)
	);

endmodule

`default_nettype wire

// ==== tb_codec_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_codec_sram (
	input  logic i_clk,
	input  logic [19:0] i_sram_addr,
	inout  wire  [15:0] io_sram_dq,
	input  logic i_sram_we_n,
	input  logic i_sram_oe_n,
	output logic o_bclk,
	output logic o_lrck,
	output logic o_adcdat,
	input  logic i_dacdat
);

	logic [15:0] mem [logic [19:0]];
	logic [15:0] adc_q [$];
	logic [15:0] dac_q [$];
	int frame_cnt;
	logic [2:0] div;
	logic [4:0] bit_idx;
	logic [15:0] adc_word;
	logic [15:0] dac_shift;
	logic [15:0] rd_word;

	// unwritten words read back as an address-dependent pattern
	function automatic logic [15:0] peek(input logic [19:0] a);
		if (mem.exists(a)) begin
			peek = mem[a];
		end else begin
			peek = a[15:0] ^ {a[3:0], a[19:8]} ^ 16'ha5c3;
		end
	endfunction

	function automatic logic written(input logic [19:0] a);
		written = mem.exists(a);
	endfunction

	initial begin
		o_bclk    = 1'b1;
		o_lrck    = 1'b1;
		o_adcdat  = 1'b0;
		div       = 3'd1;
		bit_idx   = 5'd31;
		frame_cnt = 0;
		adc_word  = '0;
		dac_shift = '0;
		rd_word   = '0;
	end

	// asynchronous SRAM, sampled mid-cycle
	always @(negedge i_clk) begin
		if (!i_sram_we_n) begin
			mem[i_sram_addr] = io_sram_dq;
		end
		rd_word = peek(i_sram_addr);
	end

	assign io_sram_dq = (!i_sram_oe_n && i_sram_we_n) ? rd_word : 'z;

	// I2S master, BCLK is i_clk over 8, 32 BCLK per frame
	always @(negedge i_clk) begin
		div = div + 3'd1;
		if (div == 3'd4) begin
			o_bclk = 1'b1;
			if (bit_idx >= 5'd1 && bit_idx <= 5'd16) begin
				dac_shift = {dac_shift[14:0], i_dacdat};
				if (bit_idx == 5'd16) begin
					dac_q.push_back(dac_shift);
				end
			end
		end else if (div == 3'd0) begin
			o_bclk  = 1'b0;
			bit_idx = bit_idx + 5'd1;
			if (bit_idx == 5'd0) begin
				o_lrck    = 1'b0;
				frame_cnt = frame_cnt + 1;
			end
			if (bit_idx == 5'd16) begin
				o_lrck = 1'b1;
			end
			if (bit_idx == 5'd1) begin
				adc_word = (adc_q.size() > 0) ? adc_q.pop_front() : 16'h0000;
			end
			if (bit_idx >= 5'd1 && bit_idx <= 5'd16) begin
				o_adcdat = adc_word[5'd16 - bit_idx];
			end else begin
				o_adcdat = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb_audio_board.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_audio_board;

	logic i_clk;
	logic i_rst_n;
	logic [2:0] i_key;
	logic [17:0] i_sw;
	logic [19:0] sram_addr;
	wire  [15:0] sram_dq;
	logic sram_we_n;
	logic sram_ce_n;
	logic sram_oe_n;
	logic sram_lb_n;
	logic sram_ub_n;
	logic bclk;
	logic lrck;
	logic adcdat;
	logic dacdat;
	logic [6:0] hex0;
	logic [6:0] hex1;
	logic [6:0] hex2;
	logic [6:0] hex3;
	logic [6:0] hex4;
	logic [6:0] hex5;
	logic [6:0] hex6;
	logic [6:0] hex7;
	logic [8:0] ledg;
	logic [17:0] ledr;
	logic [31:0] lfsr_state;
	logic [15:0] rec_words [$];
	int n_checks;
	int n_errors;
	int test_errors;
	int recip_tab [1:8] = '{4096, 2048, 1365, 1024, 819, 683, 585, 512};

	audio_board UUT (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_key         (i_key),
		.i_sw          (i_sw),
		.o_sram_addr   (sram_addr),
		.io_sram_dq    (sram_dq),
		.o_sram_we_n   (sram_we_n),
		.o_sram_ce_n   (sram_ce_n),
		.o_sram_oe_n   (sram_oe_n),
		.o_sram_lb_n   (sram_lb_n),
		.o_sram_ub_n   (sram_ub_n),
		.i_aud_adcdat  (adcdat),
		.i_aud_adclrck (lrck),
		.i_aud_bclk    (bclk),
		.i_aud_daclrck (lrck),
		.o_aud_dacdat  (dacdat),
		.o_hex0        (hex0),
		.o_hex1        (hex1),
		.o_hex2        (hex2),
		.o_hex3        (hex3),
		.o_hex4        (hex4),
		.o_hex5        (hex5),
		.o_hex6        (hex6),
		.o_hex7        (hex7),
		.o_ledg        (ledg),
		.o_ledr        (ledr)
	);

	tb_codec_sram codec (
		.i_clk       (i_clk),
		.i_sram_addr (sram_addr),
		.io_sram_dq  (sram_dq),
		.i_sram_we_n (sram_we_n),
		.i_sram_oe_n (sram_oe_n),
		.o_bclk      (bclk),
		.o_lrck      (lrck),
		.o_adcdat    (adcdat),
		.i_dacdat    (dacdat)
	);

	always #20 i_clk = ~i_clk;

	// taps 32 22 2 1
	function automatic logic lfsr_bit();
		logic nb;
		nb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], nb};
		lfsr_bit = nb;
	endfunction

	function automatic logic [15:0] lfsr_word();
		logic [15:0] w;
		w = '0;
		for (int i = 0; i < 16; i++) begin
			w = {w[14:0], lfsr_bit()};
		end
		lfsr_word = w;
	endfunction

	// active low, g in bit 6
	function automatic logic [6:0] seg_code(input logic [3:0] h);
		logic [6:0] s;
		case (h)
			4'h0: s = 7'h40;
			4'h1: s = 7'h79;
			4'h2: s = 7'h24;
			4'h3: s = 7'h30;
			4'h4: s = 7'h19;
			4'h5: s = 7'h12;
			4'h6: s = 7'h02;
			4'h7: s = 7'h78;
			4'h8: s = 7'h00;
			4'h9: s = 7'h10;
			4'ha: s = 7'h08;
			4'hb: s = 7'h03;
			4'hc: s = 7'h46;
			4'hd: s = 7'h21;
			4'he: s = 7'h06;
			default: s = 7'h0e;
		endcase
		seg_code = s;
	endfunction

	function automatic logic [audio_pkg::STATE_W-1:0] ledg_state(input logic [8:0] l);
		case (l)
			9'h001: ledg_state = audio_pkg::ST_IDLE;
			9'h002: ledg_state = audio_pkg::ST_REC;
			9'h004: ledg_state = audio_pkg::ST_REC_PAUSE;
			9'h008: ledg_state = audio_pkg::ST_PLAY;
			9'h010: ledg_state = audio_pkg::ST_PLAY_PAUSE;
			default: ledg_state = '1;
		endcase
	endfunction

	task automatic check_sample(input logic [15:0] got, input logic [15:0] exp, input string what);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			test_errors++;
			$display("ERR @%0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_state(input logic [audio_pkg::STATE_W-1:0] exp, input string what);
		logic [audio_pkg::STATE_W-1:0] got;
		got = ledg_state(ledg);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			test_errors++;
			$display("ERR @%0t: %s state %0d expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_segments(input logic [6:0] got, input logic [6:0] exp, input string what);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			test_errors++;
			$display("ERR @%0t: %s segments %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			test_errors++;
			$display("ERR @%0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_switch_leds(input logic [17:0] got, input logic [17:0] exp,
			input string what);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			test_errors++;
			$display("ERR @%0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic give_up(input string what);
		$display("timeout while waiting for %s", what);
		$display("TESTS FAILED");
		$finish;
	endtask

	task automatic wait_frame();
		int start;
		int n;
		start = codec.frame_cnt;
		n = 0;
		while (codec.frame_cnt == start) begin
			@(negedge i_clk);
			n++;
			if (n > 400) give_up("a codec frame");
		end
	endtask

	task automatic wait_state(input logic [audio_pkg::STATE_W-1:0] exp, input int max_cycles,
			input string what);
		int n;
		n = 0;
		while (ledg_state(ledg) != exp) begin
			@(negedge i_clk);
			n++;
			if (n > max_cycles) give_up(what);
		end
	endtask

	// hold long enough for the debouncer, then release
	task automatic press_key(input int idx);
		@(negedge i_clk);
		i_key[idx] = 1'b0;
		repeat (24) @(negedge i_clk);
		i_key[idx] = 1'b1;
		repeat (24) @(negedge i_clk);
	endtask

	task automatic report_test(input string name);
		$display("test %s done, %0d errors", name, test_errors);
		test_errors = 0;
	endtask

	// one word per frame, a negative skip index means no pause
	task automatic record_words(input int n, input int skip);
		logic [15:0] w;
		rec_words.delete();
		wait_frame();
		for (int i = 0; i < n; i++) begin
			w = lfsr_word();
			codec.adc_q.push_back(w);
			if (i != skip) rec_words.push_back(w);
		end
		press_key(2);
		for (int i = 1; i < n; i++) begin
			wait_frame();
			if (i == skip || i == skip + 1) press_key(1);
		end
		wait_frame();
		press_key(0);
		wait_state(audio_pkg::ST_IDLE, 200, "idle after record");
		for (int i = 0; i < rec_words.size(); i++) begin
			check_sample(codec.peek(20'(i)), rec_words[i], $sformatf("sram word %0d", i));
		end
	endtask

	task automatic test_idle_start();
		check_state(audio_pkg::ST_IDLE, "after reset");
		check_flag(sram_we_n, 1'b1, "WE_N after reset");
		check_flag(sram_oe_n, 1'b0, "OE_N after reset");
		check_flag(sram_ce_n, 1'b0, "CE_N after reset");
		check_flag(sram_lb_n, 1'b0, "LB_N after reset");
		check_flag(sram_ub_n, 1'b0, "UB_N after reset");
		check_flag(dacdat, 1'b0, "DACDAT after reset");
		// strobe and state change land well inside the key hold
		press_key(2);
		check_state(audio_pkg::ST_REC, "after start key");
		press_key(0);
		wait_state(audio_pkg::ST_IDLE, 100, "idle after stop");
		report_test("idle_start");
	endtask

	task automatic test_pause_record();
		record_words(5, 2);
		check_flag(codec.written(20'd4), 1'b0, "word past paused recording");
		report_test("pause_record");
	endtask

	task automatic test_record();
		logic [19:0] e;
		record_words(8, -1);
		e = 20'(rec_words.size() - 1);
		check_segments(hex0, seg_code(e[7:4]), "HEX0");
		check_segments(hex1, seg_code(e[11:8]), "HEX1");
		check_segments(hex2, seg_code(e[15:12]), "HEX2");
		check_segments(hex3, seg_code(e[19:16]), "HEX3");
		report_test("record");
	endtask

	task automatic test_play(input int speed, input logic fast, input logic interp,
			input string name);
		logic [15:0] exp [$];
		logic [15:0] prev;
		longint m;
		int f;
		int base;
		f = speed + 1;
		prev = '0;
		for (int a = 0; a < rec_words.size(); a = a + (fast ? f : 1)) begin
			for (int k = 0; k < (fast ? 1 : f); k++) begin
				m = longint'($signed(prev)) * (f - k) + longint'($signed(rec_words[a])) * k;
				m = (m * recip_tab[f]) >>> 12;
				exp.push_back((fast || !interp) ? rec_words[a] : m[15:0]);
			end
			prev = rec_words[a];
		end
		i_sw = '0;
		i_sw[16:14] = speed[2:0];
		i_sw[12] = fast;
		i_sw[11] = interp;
		wait_frame();
		check_switch_leds(ledr, i_sw, "LEDR");
		base = codec.dac_q.size();
		press_key(1);
		wait_state(audio_pkg::ST_PLAY, 100, "play state");
		wait_state(audio_pkg::ST_IDLE, exp.size() * 256 + 2000, "end of playback");
		wait_frame();
		wait_frame();
		if (codec.dac_q.size() < base + 1 + exp.size()) begin
			n_errors++;
			test_errors++;
			$display("%s: too few DAC frames were captured", name);
		end else begin
			for (int i = 0; i < exp.size(); i++) begin
				check_sample(codec.dac_q[base + 1 + i], exp[i], $sformatf("%s frame %0d", name, i));
			end
		end
		check_segments(hex6, seg_code(4'(f)), "HEX6 speed");
		check_segments(hex7, fast ? 7'h7f : 7'h3f, "HEX7 slow mark");
		// short recordings stay below 64K words
		check_segments(hex4, seg_code(4'd0), "HEX4 play time");
		check_segments(hex5, seg_code(4'd0), "HEX5 play time");
		report_test(name);
	endtask

	initial begin
		i_clk = 1'b0;
		i_rst_n = 1'b0;
		i_key = 3'b111;
		i_sw = '0;
		lfsr_state = 32'hd70a_7c37;
		n_checks = 0;
		n_errors = 0;
		test_errors = 0;
		repeat (10) @(negedge i_clk);
		i_rst_n = 1'b1;
		repeat (4) @(negedge i_clk);
		test_idle_start();
		test_pause_record();
		test_record();
		test_play(0, 1'b1, 1'b0, "play_x1");
		test_play(2, 1'b1, 1'b0, "play_fast3");
		test_play(1, 1'b0, 1'b0, "play_slow2");
		test_play(2, 1'b0, 1'b1, "play_interp3");
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
audio_pkg.sv
key_debounce.sv
i2s_capture.sv
i2s_playback.sv
rec_play_ctrl.sv
aud_speed_dsp.sv
audio_core.sv
seg7_status.sv
audio_board.sv
tb_codec_sram.sv
tb_audio_board.sv
